/* bit_stuffer.sv */
/*
 * Bit stuffer
 * Inserts a zero after six ones in a row, from the PID onward, and
 * stalls the serializer for that one cycle
 */

`timescale 1ns/1ps

module bit_stuffer (
  input  logic                clk,
  input  logic                rst_L,
  input  usb_tx_pkg::tx_bit_t ser_bit,
  output usb_tx_pkg::tx_bit_t stf_bit,
  output logic                stall
);

  import usb_tx_pkg::*;

  logic [2:0] run_cnt;
  logic [3:0] pos_cnt;
  logic       pend_last;
  logic       past_sync;
  logic       run_done;

  assign past_sync = (pos_cnt == 4'(SYNC_W));
  assign stall     = (run_cnt == 3'(STUFF_RUN));

  // this bit completes a run, so a zero follows it
  assign run_done = past_sync && ser_bit.valid && ser_bit.value &&
                    (run_cnt == 3'(STUFF_RUN - 1));

  always_comb begin
    stf_bit.valid = ser_bit.valid || stall;
    stf_bit.value = ser_bit.value && !stall;
    stf_bit.last  = stall ? pend_last : (ser_bit.last && !run_done);
  end

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      run_cnt   <= '0;
      pos_cnt   <= '0;
      pend_last <= 1'b0;
    end else if (stall) begin
      run_cnt   <= '0;
      pend_last <= 1'b0;
    end else if (!ser_bit.valid) begin
      // between packets
      run_cnt <= '0;
      pos_cnt <= '0;
    end else begin
      if (!past_sync) begin
        pos_cnt <= pos_cnt + 1'b1;
      end else begin
        run_cnt <= ser_bit.value ? run_cnt + 1'b1 : '0;
      end
      pend_last <= ser_bit.last && run_done;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_L) stall |=> !stall)
    else $error("stall held for two cycles in a row");

endmodule

/* crc_gen.sv */
/*
 * Serial CRC generator
 * Divides the incoming bits MSB first by POLY, then shifts out the
 * inverted remainder MSB first
 */

`timescale 1ns/1ps

module crc_gen #(
  parameter int               WIDTH = 5,
  parameter logic [WIDTH-1:0] POLY  = 5'b0_0101
) (
  input  logic clk,
  input  logic rst_L,
  input  logic start,
  input  logic shift_in,
  input  logic data_bit,
  input  logic emit,
  output logic crc_bit
);

  logic [WIDTH-1:0] crc;
  logic             fb;

  // feedback of the top bit and the new message bit
  assign fb = crc[WIDTH-1] ^ data_bit;

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      crc <= '1;
    end else if (start) begin
      crc <= '1;
    end else if (shift_in) begin
      crc <= {crc[WIDTH-2:0], 1'b0} ^ (fb ? POLY : '0);
    end else if (emit) begin
      crc <= {crc[WIDTH-2:0], 1'b0};
    end
  end

  // remainder goes out complemented
  assign crc_bit = ~crc[WIDTH-1];

endmodule

/* line_driver.sv */
/*
 * Line driver
 * Puts coded levels on D+/D- as J or K, closes each packet with
 * SE0 SE0 J, and drives the output enable and the done pulse
 */

`timescale 1ns/1ps

module line_driver (
  input  logic                clk,
  input  logic                rst_L,
  input  usb_tx_pkg::tx_bit_t nrz_bit,
  output logic                dp,
  output logic                dm,
  output logic                oe,
  output logic                done
);

  import usb_tx_pkg::*;

  typedef enum logic [2:0] {IDLE, DATA, SE0_A, SE0_B, EOP_J} state_e;

  state_e state;
  logic   lvl_q;
  logic   last_q;
  line_e  sym;

  always_ff @(posedge clk) begin
    lvl_q <= nrz_bit.value;
  end

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state  <= IDLE;
      last_q <= 1'b0;
    end else begin
      last_q <= nrz_bit.valid && nrz_bit.last;
      case (state)
        IDLE:    if (nrz_bit.valid) state <= DATA;
        DATA:    if (last_q) state <= SE0_A;
        SE0_A:   state <= SE0_B;
        SE0_B:   state <= EOP_J;
        EOP_J:   state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    sym  = LINE_SE0;
    oe   = 1'b1;
    done = 1'b0;
    case (state)
      DATA:         sym = lvl_q ? LINE_J : LINE_K;
      SE0_A, SE0_B: sym = LINE_SE0;
      EOP_J: begin
        sym  = LINE_J;
        done = 1'b1;
      end
      default:      oe = 1'b0;
    endcase
  end

  assign {dp, dm} = sym;

  assert property (@(posedge clk) disable iff (!rst_L) !(dp && dm))
    else $error("dp and dm driven high together");

endmodule

/* nrzi_encoder.sv */
/*
 * NRZI encoder
 * A zero toggles the line level, a one keeps it; the level returns to J
 * whenever no bit is in flight
 */

`timescale 1ns/1ps

module nrzi_encoder (
  input  logic                clk,
  input  logic                rst_L,
  input  usb_tx_pkg::tx_bit_t stf_bit,
  output usb_tx_pkg::tx_bit_t nrz_bit
);

  import usb_tx_pkg::*;

  // 1 is J, 0 is K
  logic level;
  logic vld_q;
  logic last_q;

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      level  <= 1'b1;
      vld_q  <= 1'b0;
      last_q <= 1'b0;
    end else begin
      vld_q  <= stf_bit.valid;
      last_q <= stf_bit.valid && stf_bit.last;
      if (!stf_bit.valid) begin
        level <= 1'b1;
      end else if (!stf_bit.value) begin
        level <= !level;
      end
    end
  end

  assign nrz_bit = '{valid: vld_q, value: level, last: last_q};

endmodule

/* packet_serializer.sv */
/*
 * Packet serializer
 * Latches an accepted packet and emits SYNC, PID, fields and CRC as a
 * bit stream, one bit per cycle, holding while the stuffer stalls
 */

`timescale 1ns/1ps

module packet_serializer (
  input  logic                 clk,
  input  logic                 rst_L,
  input  logic                 pkt_valid,
  input  usb_tx_pkg::usb_pkt_t pkt,
  output logic                 pkt_ready,
  input  logic                 stall,
  output usb_tx_pkg::tx_bit_t  ser_bit
);

  import usb_tx_pkg::*;

  typedef enum logic [2:0] {IDLE, SYNC, PID, ADDR, ENDP, CRC5, DATA, CRC16} state_e;

  state_e     state;
  state_e     next_state;
  usb_pkt_t   pkt_q;
  logic [5:0] bit_cnt;
  logic [5:0] last_idx;
  logic [2:0] drain_cnt;
  logic       accept;
  logic       field_end;
  logic       pkt_end;
  logic       bit_val;
  logic       crc5_bit;
  logic       crc16_bit;

  // ready only once the previous packet has left the line
  assign pkt_ready = (state == IDLE) && (drain_cnt == '0);
  assign accept    = pkt_valid && pkt_ready;

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_q <= pkt;
    end
  end

  // current bit, field length and the field that follows
  always_comb begin
    bit_val    = 1'b0;
    last_idx   = '0;
    next_state = IDLE;
    case (state)
      SYNC: begin
        bit_val    = SYNC_PATTERN[bit_cnt[2:0]];
        last_idx   = 6'(SYNC_W - 1);
        next_state = PID;
      end
      PID: begin
        bit_val  = pkt_q.pid[bit_cnt[2:0]];
        last_idx = 6'(PID_W - 1);
        case (pkt_q.pid)
          PID_OUT, PID_IN: next_state = ADDR;
          PID_DATA0:       next_state = DATA;
          // handshakes and unknown codes stop after the PID
          default:         next_state = IDLE;
        endcase
      end
      ADDR: begin
        bit_val    = pkt_q.addr[bit_cnt[2:0]];
        last_idx   = 6'(ADDR_W - 1);
        next_state = ENDP;
      end
      ENDP: begin
        bit_val    = pkt_q.endp[bit_cnt[1:0]];
        last_idx   = 6'(ENDP_W - 1);
        next_state = CRC5;
      end
      CRC5: begin
        bit_val  = crc5_bit;
        last_idx = 6'(CRC5_W - 1);
      end
      DATA: begin
        bit_val    = pkt_q.data[bit_cnt];
        last_idx   = 6'(DATA_W - 1);
        next_state = CRC16;
      end
      CRC16: begin
        bit_val  = crc16_bit;
        last_idx = 6'(CRC16_W - 1);
      end
      default: begin
        bit_val = 1'b0;
      end
    endcase
  end

  assign field_end = (state != IDLE) && (bit_cnt == last_idx);
  assign pkt_end   = field_end && (next_state == IDLE);

  assign ser_bit = '{valid: (state != IDLE), value: bit_val, last: pkt_end};

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state     <= IDLE;
      bit_cnt   <= '0;
      drain_cnt <= '0;
    end else if (state == IDLE) begin
      // a trailing stuffed zero lengthens the drain by one
      if (drain_cnt != '0 && !stall) begin
        drain_cnt <= drain_cnt - 1'b1;
      end
      if (accept) begin
        state   <= SYNC;
        bit_cnt <= '0;
      end
    end else if (!stall) begin
      if (field_end) begin
        bit_cnt <= '0;
        state   <= next_state;
        if (pkt_end) begin
          drain_cnt <= 3'(TX_DRAIN);
        end
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  crc_gen #(.WIDTH(CRC5_W), .POLY(CRC5_POLY)) crc5_inst (
    .clk      (clk),
    .rst_L    (rst_L),
    .start    (accept),
    .shift_in (!stall && (state == ADDR || state == ENDP)),
    .data_bit (bit_val),
    .emit     (!stall && state == CRC5),
    .crc_bit  (crc5_bit)
  );

  crc_gen #(.WIDTH(CRC16_W), .POLY(CRC16_POLY)) crc16_inst (
    .clk      (clk),
    .rst_L    (rst_L),
    .start    (accept),
    .shift_in (!stall && state == DATA),
    .data_bit (bit_val),
    .emit     (!stall && state == CRC16),
    .crc_bit  (crc16_bit)
  );

  // the source holds a packet until it is taken
  assert property (@(posedge clk) disable iff (!rst_L)
    pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt))
    else $error("pkt_valid or pkt changed while pkt_ready was low");

  // once the final bit moves on, the stream goes quiet
  assert property (@(posedge clk) disable iff (!rst_L)
    ser_bit.last && !stall |-> ser_bit.valid ##1 !ser_bit.valid)
    else $error("serializer last flag not at the end of a valid packet");

endmodule

/* tb.f */
usb_tx_pkg.sv
crc_gen.sv
packet_serializer.sv
bit_stuffer.sv
nrzi_encoder.sv
line_driver.sv
usb_tx.sv
tb_line_monitor.sv
tb_usb_tx.sv

/* tb_line_monitor.sv */
/*
 * Line monitor for the USB transmitter testbench
 * Decodes NRZI on D+/D-, removes stuffed zeros and reports each
 * packet with the shape of its EOP and the done pulses seen
 */

`timescale 1ns/1ps

module tb_line_monitor (
  input  logic         clk,
  input  logic         rst_L,
  input  logic         dp,
  input  logic         dm,
  input  logic         oe,
  input  logic         done,
  output logic [127:0] cap_bits,
  output int           cap_len,
  output int           cap_stuffed,
  output logic         cap_eop_ok,
  output int           cap_dones,
  output int           cap_count
);

  logic [127:0] bits;
  int           len;
  int           stuffed;
  int           ones;
  int           se0_n;
  int           done_n;
  logic         prev;
  logic         active;
  logic         b;

  // sampled on the falling edge, half a cycle away from the driver
  always @(negedge clk or negedge rst_L) begin
    if (!rst_L) begin
      active = 1'b0;
      cap_bits    <= '0;
      cap_len     <= 0;
      cap_stuffed <= 0;
      cap_eop_ok  <= 1'b0;
      cap_dones   <= 0;
      cap_count   <= 0;
    end else if (oe) begin
      if (!active) begin
        // line was idle J before the first SYNC bit
        active  = 1'b1;
        bits    = '0;
        len     = 0;
        stuffed = 0;
        ones    = 0;
        se0_n   = 0;
        done_n  = 0;
        prev    = 1'b1;
      end
      if (done) begin
        done_n = done_n + 1;
      end
      if (!dp && !dm) begin
        se0_n = se0_n + 1;
      end else if (se0_n == 0) begin
        // no transition means a one
        b    = (dp == prev);
        prev = dp;
        if (len >= 8 && ones == 6 && !b) begin
          stuffed = stuffed + 1;
          ones    = 0;
        end else begin
          if (len >= 8) ones = b ? ones + 1 : 0;
          if (len < 128) bits[len] = b;
          len = len + 1;
        end
      end else begin
        // first level after SE0 closes the packet
        cap_bits    <= bits;
        cap_len     <= len;
        cap_stuffed <= stuffed;
        cap_eop_ok  <= (se0_n == 2) && dp && !dm;
        cap_dones   <= done_n;
        cap_count   <= cap_count + 1;
        active = 1'b0;
      end
    end else if (active) begin
      // line released without a closing J
      cap_eop_ok <= 1'b0;
      cap_count  <= cap_count + 1;
      active = 1'b0;
    end
  end

endmodule

/* tb_usb_tx.sv */
/*
 * Testbench for the USB full-speed transmitter
 * Sends tokens, data and handshake packets from a table and checks the
 * decoded line, the stuffing, the EOP and the ready/done timing
 */

`timescale 1ns/1ps

module tb_usb_tx;

  import usb_tx_pkg::*;

  localparam int          NUM_RAND  = 3;
  localparam int          TIMEOUT   = 500;
  localparam logic [7:0]  SYNC_BITS = 8'b1000_0000;
  localparam logic [15:0] POLY5     = 16'h0005;
  localparam logic [15:0] POLY16    = 16'h8005;

  typedef struct packed {
    pid_e      pid;
    usb_addr_t addr;
    usb_endp_t endp;
    usb_data_t data;
    // next packet is held valid while this one goes out
    logic      back;
  } entry_t;

  logic         clk;
  logic         rst_L;
  logic         pkt_valid;
  usb_pkt_t     pkt;
  logic         pkt_ready;
  logic         dp;
  logic         dm;
  logic         oe;
  logic         done;
  logic [127:0] cap_bits;
  int           cap_len;
  int           cap_stuffed;
  logic         cap_eop_ok;
  int           cap_dones;
  int           cap_count;
  integer       seed;
  entry_t       tab[$];
  logic [15:0]  exp_crc[$];
  int           exp_stuff[$];

  always #50 clk = ~clk;

  usb_tx usb_tx_inst (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt_valid (pkt_valid),
    .pkt       (pkt),
    .pkt_ready (pkt_ready),
    .dp        (dp),
    .dm        (dm),
    .oe        (oe),
    .done      (done)
  );

  tb_line_monitor monitor_inst (
    .clk         (clk),
    .rst_L       (rst_L),
    .dp          (dp),
    .dm          (dm),
    .oe          (oe),
    .done        (done),
    .cap_bits    (cap_bits),
    .cap_len     (cap_len),
    .cap_stuffed (cap_stuffed),
    .cap_eop_ok  (cap_eop_ok),
    .cap_dones   (cap_dones),
    .cap_count   (cap_count)
  );

  task automatic stop_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_idle();
    check("oe", oe, 1'b0);
    check("done", done, 1'b0);
    check("dp", dp, 1'b0);
    check("dm", dm, 1'b0);
    check("pkt_ready", pkt_ready, 1'b1);
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    while (!(pkt_valid && pkt_ready)) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        $display("timeout: the packet was never accepted");
        stop_run();
      end
    end
  endtask

  // pkt_ready must stay low until the done pulse
  task automatic wait_done();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        $display("timeout: no done pulse after the packet was accepted");
        stop_run();
      end
      check("pkt_ready", pkt_ready, 1'b0);
    end while (!done);
  endtask

  function automatic usb_pkt_t to_pkt(input entry_t e);
    return '{pid: e.pid, addr: e.addr, endp: e.endp, data: e.data};
  endfunction

  // preload ones, divide bit by bit, send the complement
  function automatic logic [15:0] crc_calc(input logic [127:0] bits, input int first,
                                           input int n, input int width,
                                           input logic [15:0] poly);
    logic [15:0] mask;
    logic [15:0] rem;
    logic        top;
    mask = 16'((32'd1 << width) - 1);
    rem  = mask;
    for (int i = 0; i < n; i++) begin
      top = rem[width-1] ^ bits[first + i];
      rem = (rem << 1) & mask;
      if (top) rem = rem ^ poly;
    end
    return ~rem & mask;
  endfunction

  // bit i is the i-th bit on the wire before stuffing
  function automatic int build_bits(input entry_t e, output logic [127:0] bits,
                                    output logic [15:0] crc);
    int n;
    bits = '0;
    crc  = '0;
    for (int i = 0; i < 8; i++) bits[i] = SYNC_BITS[i];
    for (int i = 0; i < 8; i++) bits[8 + i] = e.pid[i];
    n = 16;
    if (e.pid == PID_OUT || e.pid == PID_IN) begin
      for (int i = 0; i < 7; i++) bits[16 + i] = e.addr[i];
      for (int i = 0; i < 4; i++) bits[23 + i] = e.endp[i];
      crc = crc_calc(bits, 16, 11, 5, POLY5);
      for (int i = 0; i < 5; i++) bits[27 + i] = crc[4 - i];
      n = 32;
    end else if (e.pid == PID_DATA0) begin
      for (int i = 0; i < 64; i++) bits[16 + i] = e.data[i];
      crc = crc_calc(bits, 16, 64, 16, POLY16);
      for (int i = 0; i < 16; i++) bits[80 + i] = crc[15 - i];
      n = 96;
    end
    return n;
  endfunction

  // a zero goes in after every six ones, SYNC excluded
  function automatic int count_stuffs(input logic [127:0] bits, input int n);
    int ones;
    int cnt;
    ones = 0;
    cnt  = 0;
    for (int i = 8; i < n; i++) begin
      ones = bits[i] ? ones + 1 : 0;
      if (ones == 6) begin
        cnt++;
        ones = 0;
      end
    end
    return cnt;
  endfunction

  function automatic logic [15:0] msb_field(input logic [127:0] bits, input int first,
                                            input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[14:0], bits[first + i]};
    return v;
  endfunction

  task automatic check_packet(input int i);
    logic [127:0] exp_bits;
    logic [15:0]  crc;
    int           exp_len;
    exp_len = build_bits(tab[i], exp_bits, crc);
    check("packet count", cap_count, i + 1);
    check("eop", cap_eop_ok, 1'b1);
    check("done pulses", cap_dones, 1);
    check("bit count", cap_len, exp_len);
    check("sync", cap_bits[7:0], SYNC_BITS);
    check("pid", cap_bits[15:8], tab[i].pid);
    if (tab[i].pid == PID_OUT || tab[i].pid == PID_IN) begin
      check("addr", cap_bits[22:16], tab[i].addr);
      check("endp", cap_bits[26:23], tab[i].endp);
      check("crc5", msb_field(cap_bits, 27, 5), exp_crc[i]);
    end else if (tab[i].pid == PID_DATA0) begin
      check("data", cap_bits[79:16], tab[i].data);
      check("crc16", msb_field(cap_bits, 80, 16), exp_crc[i]);
    end
    check("line bits", cap_bits, exp_bits);
    check("stuffed bits", cap_stuffed, exp_stuff[i]);
  endtask

  initial begin
    logic [127:0] bits;
    logic [15:0]  crc;
    int           len;
    usb_data_t    rnd;
    clk       = 1'b0;
    rst_L     = 1'b0;
    pkt_valid = 1'b0;
    pkt       = '0;
    seed      = 32'h6627_57cc;
    tab = '{
      '{PID_OUT,   7'h00, 4'h0, 64'h0,                   1'b0},
      '{PID_OUT,   7'h15, 4'he, 64'h0,                   1'b0},
      '{PID_IN,    7'h3a, 4'ha, 64'h0,                   1'b0},
      '{PID_IN,    7'h7f, 4'hf, 64'h0,                   1'b0},
      '{PID_DATA0, 7'h00, 4'h0, 64'h0,                   1'b0},
      '{PID_DATA0, 7'h00, 4'h0, 64'hffff_ffff_ffff_ffff, 1'b0},
      '{PID_ACK,   7'h00, 4'h0, 64'h0,                   1'b1},
      '{PID_NAK,   7'h00, 4'h0, 64'h0,                   1'b1},
      '{PID_DATA0, 7'h00, 4'h0, 64'h0123_4567_89ab_cdef, 1'b0}
    };
    for (int k = 0; k < NUM_RAND; k++) begin
      rnd[63:32] = $random(seed);
      rnd[31:0]  = $random(seed);
      tab.push_back('{PID_DATA0, 7'h00, 4'h0, rnd, k == 0});
    end
    foreach (tab[i]) begin
      len = build_bits(tab[i], bits, crc);
      exp_crc.push_back(crc);
      exp_stuff.push_back(count_stuffs(bits, len));
    end

    // line must stay released through reset
    repeat (5) begin
      @(posedge clk);
      check_idle();
    end
    rst_L <= 1'b1;

    for (int i = 0; i < tab.size(); i++) begin
      if (!pkt_valid) begin
        pkt_valid <= 1'b1;
        pkt       <= to_pkt(tab[i]);
      end
      wait_accept();
      if (tab[i].back && i + 1 < tab.size()) begin
        pkt <= to_pkt(tab[i + 1]);
      end else begin
        pkt_valid <= 1'b0;
      end
      wait_done();
      check_packet(i);
      @(posedge clk);
      check_idle();
      if (!pkt_valid) begin
        @(posedge clk);
        check_idle();
      end
    end
    $display("No errors");
    $finish;
  end

endmodule

/* usb_tx.sv */
/*
 * USB full-speed host transmitter
 * Serializer, bit stuffer, NRZI encoder and line driver in a chain
 */

`timescale 1ns/1ps

module usb_tx (
  input  logic                 clk,
  input  logic                 rst_L,
  input  logic                 pkt_valid,
  input  usb_tx_pkg::usb_pkt_t pkt,
  output logic                 pkt_ready,
  output logic                 dp,
  output logic                 dm,
  output logic                 oe,
  output logic                 done
);

  import usb_tx_pkg::*;

  tx_bit_t ser_bit;
  tx_bit_t stf_bit;
  tx_bit_t nrz_bit;
  logic    stall;

  packet_serializer serializer_inst (
    .clk       (clk),
    .rst_L     (rst_L),
    .pkt_valid (pkt_valid),
    .pkt       (pkt),
    .pkt_ready (pkt_ready),
    .stall     (stall),
    .ser_bit   (ser_bit)
  );

  bit_stuffer stuffer_inst (
    .clk     (clk),
    .rst_L   (rst_L),
    .ser_bit (ser_bit),
    .stf_bit (stf_bit),
    .stall   (stall)
  );

  nrzi_encoder nrzi_inst (
    .clk     (clk),
    .rst_L   (rst_L),
    .stf_bit (stf_bit),
    .nrz_bit (nrz_bit)
  );

  line_driver driver_inst (
    .clk     (clk),
    .rst_L   (rst_L),
    .nrz_bit (nrz_bit),
    .dp      (dp),
    .dm      (dm),
    .oe      (oe),
    .done    (done)
  );

endmodule

/* usb_tx_pkg.sv */
/*
 * USB full-speed transmit definitions
 * PID codes, field widths, CRC polynomials, line symbols and the
 * packet and bit-stream structs shared by the transmit pipeline
 */

package usb_tx_pkg;

  // field widths as they appear on the wire
  localparam int SYNC_W = 8;
  localparam int PID_W  = 8;
  localparam int ADDR_W = 7;
  localparam int ENDP_W = 4;
  localparam int DATA_W = 64;

  // PID byte including its check nibble, sent LSB first
  typedef enum logic [PID_W-1:0] {
    PID_OUT   = 8'b1110_0001,
    PID_IN    = 8'b0110_1001,
    PID_DATA0 = 8'b1100_0011,
    PID_ACK   = 8'b1101_0010,
    PID_NAK   = 8'b0101_1010
  } pid_e;

  typedef logic [ADDR_W-1:0] usb_addr_t;
  typedef logic [ENDP_W-1:0] usb_endp_t;
  typedef logic [DATA_W-1:0] usb_data_t;

  typedef struct packed {
    pid_e      pid;
    usb_addr_t addr;
    usb_endp_t endp;
    usb_data_t data;
  } usb_pkt_t;

  // one bit moving between pipeline stages
  typedef struct packed {
    logic valid;
    logic value;
    logic last;
  } tx_bit_t;

  // token CRC, x^5 + x^2 + 1
  localparam int              CRC5_W    = 5;
  localparam logic [CRC5_W-1:0] CRC5_POLY = 5'b0_0101;

  // data CRC, x^16 + x^15 + x^2 + 1
  localparam int               CRC16_W    = 16;
  localparam logic [CRC16_W-1:0] CRC16_POLY = 16'h8005;

  // seven zeros then a one, before NRZI coding
  localparam logic [SYNC_W-1:0] SYNC_PATTERN = 8'b1000_0000;

  localparam int STUFF_RUN      = 6;
  localparam int EOP_SE0_CYCLES = 2;

  // cycles from the final serialized bit to the end of the closing J:
  // nrzi register, line register, SE0 cycles, J
  localparam int TX_DRAIN = 2 + EOP_SE0_CYCLES + 1;

  // line symbols as {dp, dm}
  typedef enum logic [1:0] {
    LINE_SE0 = 2'b00,
    LINE_K   = 2'b01,
    LINE_J   = 2'b10
  } line_e;

endpackage
